// ==== source/apb_slaves_defs.svh ====
// APB peripheral subsystem constants

`ifndef APB_SLAVES_DEFS_SVH
`define APB_SLAVES_DEFS_SVH

////////////////////////////////////////////////////////////
// APB4 bus widths
////////////////////////////////////////////////////////////

`define APB_ADDR_W        12
`define APB_DATA_W        32
`define APB_STRB_W        (`APB_DATA_W / 8)
`define APB_PROT_W        3

////////////////////////////////////////////////////////////
// Address map
////////////////////////////////////////////////////////////

// PLIC occupies the lowest 1 KB
`define PLIC_BASE         12'h000
`define PLIC_REGION_W     10

// Two user windows of 1 KB from 0x800, 0x400-0x7FF left unmapped
`define USR_CNT           2
`define USR_BASE          12'h800
`define USR_REGION_W      10

////////////////////////////////////////////////////////////
// PLIC sources and registers
////////////////////////////////////////////////////////////

`define PLIC_SOURCES      6
`define PLIC_ID_W         3
`define PLIC_PRIO_W       2

// Source IDs, 0 reserved for none
`define PLIC_ID_JSP       1
`define PLIC_ID_UART      2
`define PLIC_ID_GPIO      3
`define PLIC_ID_I2C       4
`define PLIC_ID_SPI       5
`define PLIC_ID_USR       6

// Register offsets inside the PLIC window
`define PLIC_PRIO_OFFS    10'h000
`define PLIC_PEND_OFFS    10'h100
`define PLIC_EN_OFFS      10'h200
`define PLIC_THR_OFFS     10'h300
`define PLIC_CLAIM_OFFS   10'h304

`endif

// ==== source/apb_slaves_pkg.sv ====
// APB peripheral subsystem types

`include "apb_slaves_defs.svh"

package apb_slaves_pkg;

  ////////////////////////////////////////////////////////////
  // Plain vectors
  ////////////////////////////////////////////////////////////

  typedef logic [`APB_ADDR_W-1:0]    apb_addr_t;
  typedef logic [`APB_DATA_W-1:0]    apb_data_t;
  typedef logic [`APB_STRB_W-1:0]    apb_strb_t;
  typedef logic [`USR_REGION_W-1:0]  usr_addr_t;

  // Byte offset inside the PLIC window
  typedef logic [`PLIC_REGION_W-1:0] plic_offs_t;

  typedef logic [`PLIC_ID_W-1:0]     plic_id_t;
  typedef logic [`PLIC_PRIO_W-1:0]   plic_prio_t;

  // Bit n belongs to source ID n, no bit for ID 0
  typedef logic [`PLIC_SOURCES:1]    plic_src_t;

  ////////////////////////////////////////////////////////////
  // Bus bundles
  ////////////////////////////////////////////////////////////

  // Master side request
  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`APB_PROT_W-1:0] pprot;
    apb_strb_t              pstrb;
    apb_addr_t              paddr;
    apb_data_t              pwdata;
  } apb_req_t;

  // Slave response, shared by every slave
  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  // Request on a user bus, address cut to the window
  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`APB_PROT_W-1:0] pprot;
    apb_strb_t              pstrb;
    usr_addr_t              paddr;
    apb_data_t              pwdata;
  } usr_req_t;

endpackage

// ==== source/apb_decoder.sv ====
// APB4 address decoder and response mux

`timescale 1ns/100ps

`include "apb_slaves_defs.svh"

module apb_decoder (
  // Clock and reset only feed the bound protocol checks
  input  logic                                   PCLK,
  input  logic                                   reset_i,
  input  apb_slaves_pkg::apb_req_t               mst_req_i,
  output apb_slaves_pkg::apb_rsp_t               mst_rsp_o,
  output logic                                   plic_sel_o,
  output logic [`USR_CNT-1:0]                    usr_sel_o,
  input  apb_slaves_pkg::apb_rsp_t               plic_rsp_i,
  input  apb_slaves_pkg::apb_rsp_t [`USR_CNT-1:0] usr_rsp_i
);

  import apb_slaves_pkg::*;

  // Offset bits inside each window masked off
  localparam apb_addr_t plic_mask = ~apb_addr_t'((1 << `PLIC_REGION_W) - 1);
  localparam apb_addr_t usr_mask  = ~apb_addr_t'((1 << `USR_REGION_W) - 1);

  // Window match flags
  logic                plic_hit;
  logic [`USR_CNT-1:0] usr_hit;
  // Selected but claimed by nobody
  logic                err_hit;

  ////////////////////////////////////////////////////////////
  // Select generation
  ////////////////////////////////////////////////////////////

  always_comb begin
    plic_hit = (mst_req_i.paddr & plic_mask) == `PLIC_BASE;
    // User windows sit back to back from the user base
    for (int n = 0; n < `USR_CNT; n++) begin
      usr_hit[n] = (mst_req_i.paddr & usr_mask) ==
                   apb_addr_t'(`USR_BASE + n * (1 << `USR_REGION_W));
    end
    // Gap between PLIC and user windows
    err_hit = mst_req_i.psel & ~plic_hit & ~(|usr_hit);
  end

  // Disjoint windows give one select at most
  assign plic_sel_o = mst_req_i.psel & plic_hit;
  assign usr_sel_o  = {`USR_CNT{mst_req_i.psel}} & usr_hit;

  ////////////////////////////////////////////////////////////
  // Response mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Idle bus reads as ready with no error
    mst_rsp_o.prdata  = '0;
    mst_rsp_o.pready  = 1'b1;
    mst_rsp_o.pslverr = 1'b0;
    if (plic_sel_o) begin
      mst_rsp_o = plic_rsp_i;
    end
    // User wait states pass straight through
    for (int n = 0; n < `USR_CNT; n++) begin
      if (usr_sel_o[n]) begin
        mst_rsp_o = usr_rsp_i[n];
      end
    end
    // Unmapped access ends in its first access cycle with zero data
    if (err_hit) begin
      mst_rsp_o.pslverr = mst_req_i.penable;
    end
  end

endmodule

// ==== source/plic_gateway.sv ====
// PLIC interrupt gateway

`timescale 1ns/100ps

`include "apb_slaves_defs.svh"

module plic_gateway #(
  parameter int NUM_SRC = `PLIC_SOURCES
) (
  input  logic                      PCLK,
  input  logic                      reset_i,
  // Raw interrupt levels in ID order
  input  apb_slaves_pkg::plic_src_t src_i,
  // Claim strobe from the register block
  input  logic                      claim_i,
  input  apb_slaves_pkg::plic_id_t  claim_id_i,
  // Handler done strobe
  input  logic                      complete_i,
  input  apb_slaves_pkg::plic_id_t  complete_id_i,
  output apb_slaves_pkg::plic_src_t pending_o,
  output apb_slaves_pkg::plic_src_t in_service_o
);

  import apb_slaves_pkg::*;

  // Next state of both vectors
  plic_src_t pend_d;
  plic_src_t serv_d;

  ////////////////////////////////////////////////////////////
  // Per-source gating
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Bits above NUM_SRC stay clear
    pend_d = '0;
    serv_d = '0;
    for (int n = 1; n <= NUM_SRC; n++) begin
      pend_d[n] = pending_o[n];
      serv_d[n] = in_service_o[n];

      // Capture a level only when the source is idle
      if (src_i[n] && !pending_o[n] && !in_service_o[n]) begin
        pend_d[n] = 1'b1;
      end

      // Claim moves pending into service
      if (claim_i && claim_id_i == plic_id_t'(n) && pending_o[n]) begin
        pend_d[n] = 1'b0;
        serv_d[n] = 1'b1;
      end

      // Complete reopens the gate, next level is seen one edge later
      if (complete_i && complete_id_i == plic_id_t'(n)) begin
        serv_d[n] = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // State registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge PCLK) begin
    if (reset_i) begin
      pending_o    <= '0;
      in_service_o <= '0;
    end else begin
      pending_o    <= pend_d;
      in_service_o <= serv_d;
    end
  end

endmodule

// ==== source/plic_core.sv ====
// PLIC register block and target logic

`timescale 1ns/100ps

`include "apb_slaves_defs.svh"

module plic_core (
  input  logic                      PCLK,
  input  logic                      reset_i,
  input  logic                      sel_i,
  input  apb_slaves_pkg::apb_req_t  req_i,
  output apb_slaves_pkg::apb_rsp_t  rsp_o,
  // Gateway state
  input  apb_slaves_pkg::plic_src_t pending_i,
  input  apb_slaves_pkg::plic_src_t in_service_i,
  // Gateway strobes
  output logic                      claim_o,
  output apb_slaves_pkg::plic_id_t  claim_id_o,
  output logic                      complete_o,
  output apb_slaves_pkg::plic_id_t  complete_id_o,
  output logic                      irq_o
);

  import apb_slaves_pkg::*;

  // Configuration registers
  plic_prio_t prio [1:`PLIC_SOURCES];
  plic_src_t  enable;
  plic_prio_t threshold;

  // Access decode
  logic       acc_wr;
  logic       acc_rd;
  plic_offs_t offs;
  plic_src_t  prio_sel;
  logic       cpl_busy;

  // Arbitration
  plic_prio_t best_prio;
  plic_id_t   best_id;
  plic_id_t   win_id;

  ////////////////////////////////////////////////////////////
  // Access decode
  ////////////////////////////////////////////////////////////

  // Always ready, so every access cycle completes
  assign acc_wr = sel_i & req_i.penable & req_i.pwrite;
  assign acc_rd = sel_i & req_i.penable & ~req_i.pwrite;
  assign offs   = req_i.paddr[`PLIC_REGION_W-1:0];

  always_comb begin
    prio_sel = '0;
    cpl_busy = 1'b0;
    for (int n = 1; n <= `PLIC_SOURCES; n++) begin
      // One priority word per ID at 4 x ID
      prio_sel[n] = offs == (`PLIC_PRIO_OFFS + plic_offs_t'(n * 4));
      // Written ID has to be in service
      if (complete_id_o == plic_id_t'(n) && in_service_i[n]) begin
        cpl_busy = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Highest priority pending source
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Priority 0 never wins, strict compare keeps lowest ID on ties
    best_prio = '0;
    best_id   = '0;
    for (int n = 1; n <= `PLIC_SOURCES; n++) begin
      if (pending_i[n] && enable[n] && prio[n] > best_prio) begin
        best_prio = prio[n];
        best_id   = plic_id_t'(n);
      end
    end
    // Below or at threshold counts as none
    win_id = (best_prio > threshold) ? best_id : '0;
  end

  // Claim/complete strobes to the gateway
  assign claim_o       = acc_rd & (offs == `PLIC_CLAIM_OFFS);
  assign claim_id_o    = win_id;
  assign complete_id_o = req_i.pwdata[`PLIC_ID_W-1:0];
  assign complete_o    = acc_wr & (offs == `PLIC_CLAIM_OFFS) & req_i.pstrb[0] & cpl_busy;

  ////////////////////////////////////////////////////////////
  // Registers and interrupt output
  ////////////////////////////////////////////////////////////

  always_ff @(posedge PCLK) begin
    if (reset_i) begin
      for (int n = 1; n <= `PLIC_SOURCES; n++) begin
        prio[n] <= '0;
      end
      enable    <= '0;
      threshold <= '0;
      irq_o     <= 1'b0;
    end else begin
      // All fields live in byte 0
      if (acc_wr && req_i.pstrb[0]) begin
        for (int n = 1; n <= `PLIC_SOURCES; n++) begin
          if (prio_sel[n]) begin
            prio[n] <= req_i.pwdata[`PLIC_PRIO_W-1:0];
          end
        end
        if (offs == `PLIC_EN_OFFS) begin
          enable <= req_i.pwdata[`PLIC_SOURCES:1];
        end
        if (offs == `PLIC_THR_OFFS) begin
          threshold <= req_i.pwdata[`PLIC_PRIO_W-1:0];
        end
      end
      // One edge after a qualifying pending source
      irq_o <= best_prio > threshold;
    end
  end

  // Read mux, unmapped offsets read zero
  always_comb begin
    rsp_o.prdata  = '0;
    rsp_o.pready  = 1'b1;
    rsp_o.pslverr = 1'b0;
    for (int n = 1; n <= `PLIC_SOURCES; n++) begin
      if (prio_sel[n]) begin
        rsp_o.prdata = apb_data_t'(prio[n]);
      end
    end
    if (offs == `PLIC_PEND_OFFS) begin
      rsp_o.prdata = apb_data_t'({pending_i, 1'b0});
    end
    if (offs == `PLIC_EN_OFFS) begin
      rsp_o.prdata = apb_data_t'({enable, 1'b0});
    end
    if (offs == `PLIC_THR_OFFS) begin
      rsp_o.prdata = apb_data_t'(threshold);
    end
    if (offs == `PLIC_CLAIM_OFFS) begin
      rsp_o.prdata = apb_data_t'(win_id);
    end
  end

endmodule

// ==== source/apb_slaves_top.sv ====
// APB4 peripheral subsystem top level

`timescale 1ns/100ps

`include "apb_slaves_defs.svh"

module apb_slaves_top (
  input  logic                                    PCLK,
  input  logic                                    reset_i,
  // System APB4 master port
  input  apb_slaves_pkg::apb_req_t                mst_req_i,
  output apb_slaves_pkg::apb_rsp_t                mst_rsp_o,
  // User APB4 buses
  output apb_slaves_pkg::usr_req_t [`USR_CNT-1:0] usr_req_o,
  input  apb_slaves_pkg::apb_rsp_t [`USR_CNT-1:0] usr_rsp_i,
  // Interrupt lines
  input  logic                                    int_jsp_i,
  input  logic                                    int_uart_i,
  input  logic                                    int_gpio_i,
  input  logic                                    int_i2c_i,
  input  logic                                    int_spi_i,
  input  logic                                    int_usr_i,
  output logic                                    irq_o
);

  import apb_slaves_pkg::*;

  // Decoder to slaves
  logic                plic_sel;
  logic [`USR_CNT-1:0] usr_sel;
  apb_rsp_t            plic_rsp;

  // PLIC internals
  plic_src_t           plic_src;
  plic_src_t           pending;
  plic_src_t           in_service;
  logic                claim;
  plic_id_t            claim_id;
  logic                complete;
  plic_id_t            complete_id;

  ////////////////////////////////////////////////////////////
  // Bus decode
  ////////////////////////////////////////////////////////////

  apb_decoder apb_decoder_inst (
    .PCLK       (PCLK),
    .reset_i    (reset_i),
    .mst_req_i  (mst_req_i),
    .mst_rsp_o  (mst_rsp_o),
    .plic_sel_o (plic_sel),
    .usr_sel_o  (usr_sel),
    .plic_rsp_i (plic_rsp),
    .usr_rsp_i  (usr_rsp_i)
  );

  // User requests mirror the master, address cut to window
  always_comb begin
    for (int n = 0; n < `USR_CNT; n++) begin
      usr_req_o[n].psel    = usr_sel[n];
      usr_req_o[n].penable = mst_req_i.penable;
      usr_req_o[n].pwrite  = mst_req_i.pwrite;
      usr_req_o[n].pprot   = mst_req_i.pprot;
      usr_req_o[n].pstrb   = mst_req_i.pstrb;
      usr_req_o[n].paddr   = mst_req_i.paddr[`USR_REGION_W-1:0];
      usr_req_o[n].pwdata  = mst_req_i.pwdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // Interrupt controller
  ////////////////////////////////////////////////////////////

  // Sources packed by ID
  always_comb begin
    plic_src[`PLIC_ID_JSP]  = int_jsp_i;
    plic_src[`PLIC_ID_UART] = int_uart_i;
    plic_src[`PLIC_ID_GPIO] = int_gpio_i;
    plic_src[`PLIC_ID_I2C]  = int_i2c_i;
    plic_src[`PLIC_ID_SPI]  = int_spi_i;
    plic_src[`PLIC_ID_USR]  = int_usr_i;
  end

  plic_gateway #(
    .NUM_SRC (`PLIC_SOURCES)
  ) plic_gateway_inst (
    .PCLK          (PCLK),
    .reset_i       (reset_i),
    .src_i         (plic_src),
    .claim_i       (claim),
    .claim_id_i    (claim_id),
    .complete_i    (complete),
    .complete_id_i (complete_id),
    .pending_o     (pending),
    .in_service_o  (in_service)
  );

  plic_core plic_core_inst (
    .PCLK          (PCLK),
    .reset_i       (reset_i),
    .sel_i         (plic_sel),
    .req_i         (mst_req_i),
    .rsp_o         (plic_rsp),
    .pending_i     (pending),
    .in_service_i  (in_service),
    .claim_o       (claim),
    .claim_id_o    (claim_id),
    .complete_o    (complete),
    .complete_id_o (complete_id),
    .irq_o         (irq_o)
  );

endmodule

// ==== verification/apb_slaves_asserts.sv ====
// APB decoder protocol assertions

`timescale 1ns/100ps

`include "apb_slaves_defs.svh"

module apb_slaves_asserts (
  input logic                     PCLK,
  input logic                     reset_i,
  input apb_slaves_pkg::apb_req_t mst_req_i,
  input apb_slaves_pkg::apb_rsp_t mst_rsp_o,
  input logic                     plic_sel_o,
  input logic [`USR_CNT-1:0]      usr_sel_o
);

  import apb_slaves_pkg::*;

  // Disjoint windows
  one_select: assert property (@(posedge PCLK) disable iff (reset_i)
    $onehot0({plic_sel_o, usr_sel_o}))
    else $error("more than one slave select high");

  // Waiting access holds its request
  stable_req: assert property (@(posedge PCLK) disable iff (reset_i)
    (mst_req_i.psel && mst_req_i.penable && !mst_rsp_o.pready) |=>
      (mst_req_i.psel && mst_req_i.penable && $stable(mst_req_i.paddr) &&
       $stable(mst_req_i.pwrite) && $stable(mst_req_i.pwdata) && $stable(mst_req_i.pstrb)))
    else $error("request changed while the access was waiting");

  // Setup leads into access
  setup_to_access: assert property (@(posedge PCLK) disable iff (reset_i)
    (mst_req_i.psel && !mst_req_i.penable) |=> (mst_req_i.psel && mst_req_i.penable))
    else $error("setup phase not followed by access phase");

endmodule

bind apb_decoder apb_slaves_asserts apb_slaves_asserts_inst (.*);

// ==== verification/apb_slaves_checker.sv ====
// APB subsystem response checker

`timescale 1ns/100ps

`include "apb_slaves_defs.svh"

module apb_slaves_checker (
  input  logic                                    PCLK,
  input  logic                                    reset_i,
  // Watched DUT ports
  input  apb_slaves_pkg::apb_req_t                mst_req_i,
  input  apb_slaves_pkg::apb_rsp_t                mst_rsp_i,
  input  apb_slaves_pkg::usr_req_t [`USR_CNT-1:0] usr_req_i,
  input  logic                                    irq_i,
  // Reference values
  input  apb_slaves_pkg::apb_data_t               exp_rdata_i,
  input  logic                                    exp_err_i,
  input  logic                                    exp_irq_i,
  output int                                      mismatch_cnt_o
);

  import apb_slaves_pkg::*;

  int err_cnt = 0;

  assign mismatch_cnt_o = err_cnt;

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Per-edge comparison
  ////////////////////////////////////////////////////////////

  // Sampled at the edge before any register update
  always @(posedge PCLK) begin : compare_proc
    logic sel_exp;
    logic done;
    if (!reset_i) begin
      compare("irq_o", 32'(irq_i), 32'(exp_irq_i));

      // Window n of the user map
      for (int n = 0; n < `USR_CNT; n++) begin
        sel_exp = mst_req_i.psel &&
          (mst_req_i.paddr[`APB_ADDR_W-1:`USR_REGION_W] ==
           2'((`USR_BASE >> `USR_REGION_W) + n));
        compare($sformatf("usr_req_o[%0d].psel", n), 32'(usr_req_i[n].psel), 32'(sel_exp));
        if (sel_exp && usr_req_i[n].psel) begin
          compare($sformatf("usr_req_o[%0d].paddr", n), 32'(usr_req_i[n].paddr),
                  32'(mst_req_i.paddr[`USR_REGION_W-1:0]));
          compare($sformatf("usr_req_o[%0d].pwdata", n), usr_req_i[n].pwdata,
                  mst_req_i.pwdata);
          compare($sformatf("usr_req_o[%0d].pwrite", n), 32'(usr_req_i[n].pwrite),
                  32'(mst_req_i.pwrite));
          compare($sformatf("usr_req_o[%0d].penable", n), 32'(usr_req_i[n].penable),
                  32'(mst_req_i.penable));
          compare($sformatf("usr_req_o[%0d].pstrb", n), 32'(usr_req_i[n].pstrb),
                  32'(mst_req_i.pstrb));
          compare($sformatf("usr_req_o[%0d].pprot", n), 32'(usr_req_i[n].pprot),
                  32'(mst_req_i.pprot));
        end
      end

      // PLIC and unmapped accesses never wait
      if (mst_req_i.psel && mst_req_i.penable && mst_req_i.paddr < `USR_BASE) begin
        compare("mst_rsp_o.pready", 32'(mst_rsp_i.pready), 32'd1);
      end

      // Completing access
      done = mst_req_i.psel && mst_req_i.penable && mst_rsp_i.pready;
      if (done) begin
        compare("mst_rsp_o.pslverr", 32'(mst_rsp_i.pslverr), 32'(exp_err_i));
        if (!mst_req_i.pwrite) begin
          compare("mst_rsp_o.prdata", mst_rsp_i.prdata, exp_rdata_i);
        end
      end
    end
  end

endmodule

// ==== verification/apb_slaves_tb.sv ====
// APB subsystem testbench

`timescale 1ns/100ps

`include "apb_slaves_defs.svh"

module apb_slaves_tb;

  import apb_slaves_pkg::*;

  // Cycles allowed for one handshake
  localparam int XFER_LIMIT = 20;

  logic                    PCLK;
  logic                    reset_i;
  apb_req_t                mst_req;
  apb_rsp_t                mst_rsp;
  usr_req_t [`USR_CNT-1:0] usr_req;
  apb_rsp_t [`USR_CNT-1:0] usr_rsp = '0;
  plic_src_t               int_src;
  logic                    irq;

  ////////////////////////////////////////////////////////////
  // Reference PLIC state
  ////////////////////////////////////////////////////////////

  logic [`PLIC_SOURCES:1][`PLIC_PRIO_W-1:0] ref_prio;
  plic_src_t                                ref_en;
  plic_src_t                                ref_pend;
  plic_src_t                                ref_serv;
  plic_prio_t                               ref_thr;
  logic                                     ref_irq;
  apb_data_t                                exp_rdata;
  logic                                     exp_err;

  // Wait states left per user bus
  int wait_cnt [`USR_CNT];
  int fail_cnt;
  int mismatch_cnt;

  apb_slaves_top apb_slaves_top_inst (
    .PCLK       (PCLK),
    .reset_i    (reset_i),
    .mst_req_i  (mst_req),
    .mst_rsp_o  (mst_rsp),
    .usr_req_o  (usr_req),
    .usr_rsp_i  (usr_rsp),
    .int_jsp_i  (int_src[`PLIC_ID_JSP]),
    .int_uart_i (int_src[`PLIC_ID_UART]),
    .int_gpio_i (int_src[`PLIC_ID_GPIO]),
    .int_i2c_i  (int_src[`PLIC_ID_I2C]),
    .int_spi_i  (int_src[`PLIC_ID_SPI]),
    .int_usr_i  (int_src[`PLIC_ID_USR]),
    .irq_o      (irq)
  );

  apb_slaves_checker checker_inst (
    .PCLK           (PCLK),
    .reset_i        (reset_i),
    .mst_req_i      (mst_req),
    .mst_rsp_i      (mst_rsp),
    .usr_req_i      (usr_req),
    .irq_i          (irq),
    .exp_rdata_i    (exp_rdata),
    .exp_err_i      (exp_err),
    .exp_irq_i      (ref_irq),
    .mismatch_cnt_o (mismatch_cnt)
  );

  // Highest enabled pending priority above threshold with lowest ID on ties
  function automatic plic_id_t ref_winner(
    input logic [`PLIC_SOURCES:1][`PLIC_PRIO_W-1:0] prio,
    input plic_src_t en,
    input plic_src_t pend,
    input plic_prio_t thr
  );
    plic_prio_t best;
    plic_id_t   id;
    best = '0;
    id   = '0;
    for (int n = 1; n <= `PLIC_SOURCES; n++) begin
      if (pend[n] && en[n] && prio[n] > best) begin
        best = prio[n];
        id   = plic_id_t'(n);
      end
    end
    return (best > thr) ? id : plic_id_t'(0);
  endfunction

  // Expected read data for any address of the map
  function automatic apb_data_t ref_read(
    input apb_addr_t addr,
    input logic [`PLIC_SOURCES:1][`PLIC_PRIO_W-1:0] prio,
    input plic_src_t en,
    input plic_src_t pend,
    input plic_prio_t thr
  );
    apb_data_t  d;
    plic_offs_t offs;
    d    = '0;
    offs = addr[`PLIC_REGION_W-1:0];
    if (addr < 12'h400) begin
      for (int n = 1; n <= `PLIC_SOURCES; n++) begin
        if (offs == plic_offs_t'(4 * n)) begin
          d = apb_data_t'(prio[n]);
        end
      end
      if (offs == `PLIC_PEND_OFFS) d = apb_data_t'({pend, 1'b0});
      if (offs == `PLIC_EN_OFFS) d = apb_data_t'({en, 1'b0});
      if (offs == `PLIC_THR_OFFS) d = apb_data_t'(thr);
      if (offs == `PLIC_CLAIM_OFFS) d = apb_data_t'(ref_winner(prio, en, pend, thr));
    end else if (addr >= `USR_BASE) begin
      // Slave model data has bus index high and window address low
      d = {16'((addr - `USR_BASE) >> `USR_REGION_W), 6'b0, addr[`USR_REGION_W-1:0]};
    end
    return d;
  endfunction

  always_comb begin
    exp_rdata = ref_read(mst_req.paddr, ref_prio, ref_en, ref_pend, ref_thr);
    exp_err   = (mst_req.paddr >= 12'h400) && (mst_req.paddr < `USR_BASE);
  end

  // Reference state advances on every edge
  always @(posedge PCLK) begin : ref_model
    plic_src_t  pend_n;
    plic_src_t  serv_n;
    plic_id_t   win;
    plic_offs_t offs;
    if (reset_i) begin
      ref_prio <= '0;
      ref_en   <= '0;
      ref_thr  <= '0;
      ref_pend <= '0;
      ref_serv <= '0;
      ref_irq  <= 1'b0;
    end else begin
      pend_n = ref_pend;
      serv_n = ref_serv;
      offs   = mst_req.paddr[`PLIC_REGION_W-1:0];
      win    = ref_winner(ref_prio, ref_en, ref_pend, ref_thr);
      // Idle sources latch their level
      for (int n = 1; n <= `PLIC_SOURCES; n++) begin
        if (int_src[n] && !ref_pend[n] && !ref_serv[n]) pend_n[n] = 1'b1;
      end
      // PLIC completes every access cycle
      if (mst_req.psel && mst_req.penable && mst_req.paddr < 12'h400) begin
        if (mst_req.pwrite && mst_req.pstrb[0]) begin
          for (int n = 1; n <= `PLIC_SOURCES; n++) begin
            if (offs == plic_offs_t'(4 * n)) ref_prio[n] <= mst_req.pwdata[`PLIC_PRIO_W-1:0];
            if (offs == `PLIC_CLAIM_OFFS &&
                mst_req.pwdata[`PLIC_ID_W-1:0] == plic_id_t'(n)) begin
              serv_n[n] = 1'b0;
            end
          end
          if (offs == `PLIC_EN_OFFS) ref_en <= mst_req.pwdata[`PLIC_SOURCES:1];
          if (offs == `PLIC_THR_OFFS) ref_thr <= mst_req.pwdata[`PLIC_PRIO_W-1:0];
        end
        if (!mst_req.pwrite && offs == `PLIC_CLAIM_OFFS && win != '0) begin
          pend_n[win] = 1'b0;
          serv_n[win] = 1'b1;
        end
      end
      ref_pend <= pend_n;
      ref_serv <= serv_n;
      ref_irq  <= win != '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // User bus slave models
  ////////////////////////////////////////////////////////////

  always @(posedge PCLK) begin : usr_slaves
    int w;
    for (int n = 0; n < `USR_CNT; n++) begin
      if (reset_i || !usr_req[n].psel) begin
        usr_rsp[n].pready <= 1'b0;
      end else if (!usr_req[n].penable) begin
        // Setup phase picks 0 to 3 wait states
        w = int'($urandom % 4);
        wait_cnt[n]       <= w;
        usr_rsp[n].pready <= (w == 0);
        usr_rsp[n].prdata <= {16'(n), 6'b0, usr_req[n].paddr};
      end else if (usr_rsp[n].pready) begin
        usr_rsp[n].pready <= 1'b0;
      end else begin
        wait_cnt[n]       <= wait_cnt[n] - 1;
        usr_rsp[n].pready <= (wait_cnt[n] == 1);
      end
    end
  end

  initial begin
    PCLK = 1'b0;
    forever #50 PCLK = ~PCLK;
  end

  task automatic end_run();
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  // One APB4 transfer returning at the completing edge
  task automatic apb_xfer(input apb_addr_t addr, input logic wr, input apb_data_t wdata,
                          input apb_strb_t strb, output apb_data_t rdata);
    int cnt;
    cnt   = 0;
    rdata = '0;
    @(posedge PCLK);
    mst_req.psel    <= 1'b1;
    mst_req.penable <= 1'b0;
    mst_req.pwrite  <= wr;
    mst_req.pprot   <= 3'($urandom);
    mst_req.pstrb   <= strb;
    mst_req.paddr   <= addr;
    mst_req.pwdata  <= wdata;
    @(posedge PCLK);
    mst_req.penable <= 1'b1;
    do begin
      @(posedge PCLK);
      cnt++;
    end while (!mst_rsp.pready && cnt < XFER_LIMIT);
    if (!mst_rsp.pready) begin
      fail_cnt++;
      $display("transfer to address %h never completed", addr);
      end_run();
    end else begin
      rdata           = mst_rsp.prdata;
      mst_req.psel    <= 1'b0;
      mst_req.penable <= 1'b0;
    end
  endtask

  // Global watchdog
  initial begin
    #5_000_000;
    fail_cnt++;
    $display("simulation ran past its time limit");
    end_run();
  end

  initial begin : stimulus
    apb_data_t rd;
    apb_addr_t addr;
    int        pick;
    int        cnt;
    void'($urandom(32'h4c62_5499));
    mst_req  = '0;
    int_src  = '0;
    reset_i  = 1'b1;
    fail_cnt = 0;
    repeat (10) @(posedge PCLK);
    reset_i <= 1'b0;
    @(posedge PCLK);

    // Claim after reset
    apb_xfer(12'h304, 1'b0, '0, '0, rd);

    ////////////////////////////////////////////////////////////
    // User windows and unmapped gap
    ////////////////////////////////////////////////////////////
    for (int k = 0; k < 24; k++) begin
      addr = apb_addr_t'(32'h800 + ($urandom % 32'h800));
      apb_xfer(addr, 1'($urandom), $urandom, apb_strb_t'($urandom), rd);
    end
    for (int k = 0; k < 8; k++) begin
      addr = apb_addr_t'(32'h400 + ($urandom % 32'h400));
      apb_xfer(addr, 1'($urandom), $urandom, 4'hF, rd);
    end

    // Register write and read back including pending
    for (int k = 0; k < 24; k++) begin
      pick = int'($urandom % 9);
      if (pick < 6) addr = apb_addr_t'(4 * (pick + 1));
      else if (pick == 6) addr = 12'h200;
      else if (pick == 7) addr = 12'h300;
      else addr = 12'h100;
      apb_xfer(addr, 1'b1, $urandom, apb_strb_t'($urandom), rd);
      apb_xfer(addr, 1'b0, '0, '0, rd);
    end

    ////////////////////////////////////////////////////////////
    // Random interrupts with claim and complete
    ////////////////////////////////////////////////////////////
    for (int r = 0; r < 10; r++) begin
      for (int n = 1; n <= `PLIC_SOURCES; n++) begin
        apb_xfer(apb_addr_t'(4 * n), 1'b1, $urandom, 4'hF, rd);
      end
      apb_xfer(12'h200, 1'b1, $urandom, 4'hF, rd);
      apb_xfer(12'h300, 1'b1, 32'h0, 4'hF, rd);
      int_src <= plic_src_t'($urandom);
      repeat (3) @(posedge PCLK);
      apb_xfer(12'h304, 1'b0, '0, '0, rd);
      int_src <= '0;
      if (rd != '0) begin
        apb_xfer(12'h304, 1'b1, rd, 4'hF, rd);
      end
      apb_xfer(12'h304, 1'b0, '0, '0, rd);
      // Second winner released before the next round
      if (rd != '0) begin
        apb_xfer(12'h304, 1'b1, rd, 4'hF, rd);
      end
    end

    // Threshold masks everything and then opens
    for (int n = 1; n <= `PLIC_SOURCES; n++) begin
      apb_xfer(apb_addr_t'(4 * n), 1'b1, 32'(1 + $urandom % 3), 4'hF, rd);
    end
    apb_xfer(12'h200, 1'b1, 32'h7E, 4'hF, rd);
    apb_xfer(12'h300, 1'b1, 32'h3, 4'hF, rd);
    int_src <= '1;
    repeat (4) @(posedge PCLK);
    apb_xfer(12'h304, 1'b0, '0, '0, rd);
    apb_xfer(12'h300, 1'b1, 32'h0, 4'hF, rd);
    cnt = 0;
    while (!irq && cnt < 2) begin
      @(posedge PCLK);
      cnt++;
    end
    if (!irq) begin
      fail_cnt++;
      $display("irq_o did not rise within 2 cycles of lowering the threshold");
    end
    repeat (3) @(posedge PCLK);
    end_run();
  end

endmodule

// ==== build.f ====
+incdir+source
source/apb_slaves_pkg.sv
source/apb_decoder.sv
source/plic_gateway.sv
source/plic_core.sv
source/apb_slaves_top.sv
verification/apb_slaves_asserts.sv
verification/apb_slaves_checker.sv
verification/apb_slaves_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the APB subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module apb_slaves_tb \
  -f build.f \
  -o sim_apb_slaves

./obj_dir/sim_apb_slaves > sim.log 2>&1
cat sim.log

grep -q "\*\*\* TEST PASSED \*\*\*" sim.log
echo "simulation passed"
